// File: Makefile
# Verilator flow for the hardwired control unit
TOP = tb_hdcpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o hdcpu_sim
	./obj_dir/hdcpu_sim +verilator+error+limit+1000 | tee sim.log
	grep -q -x '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: console_ctrl.sv
module console_ctrl (
    input  hdcpu_pkg::mode_e      mode,
    input  hdcpu_pkg::beat_t      w,
    input  logic                  st0,
    output hdcpu_pkg::ctrl_word_t con_word,
    output logic                  st0_set
);
    import hdcpu_pkg::*;

    logic w12;

    assign w12 = w.w1 | w.w2;

    always_comb begin
        con_word = CTRL_IDLE;
        st0_set  = 1'b0;
        case (mode)
            MODE_WR_MEM: begin
                // First pass loads AR from switches, later passes write and step
                con_word.sbus      = w.w1;
                con_word.stop      = w.w1;
                con_word.short_cyc = w.w1;
                con_word.selctl    = w.w1;
                con_word.lar       = w.w1 & ~st0;
                con_word.memw      = w.w1 & st0;
                con_word.arinc     = w.w1 & st0;
                st0_set            = w.w1;
            end
            MODE_RD_MEM: begin
                con_word.stop      = w.w1;
                con_word.short_cyc = w.w1;
                con_word.selctl    = w.w1;
                con_word.sbus      = w.w1 & ~st0;
                con_word.lar       = w.w1 & ~st0;
                con_word.mbus      = w.w1 & st0;  // Memory onto the bus
                con_word.arinc     = w.w1 & st0;
                st0_set            = w.w1 & ~st0;
            end
            MODE_RD_REG: begin
                con_word.selctl = w12;
                con_word.stop   = w12;
                if (w.w1) begin
                    con_word.sel = SEL_RD_FIRST;
                end else if (w.w2) begin
                    con_word.sel = SEL_RD_SECOND;
                end
            end
            MODE_WR_REG: begin
                con_word.sbus   = w12;
                con_word.selctl = w12;
                con_word.drw    = w12;
                con_word.stop   = w12;
                // Pass 0 writes R0/R1, pass 1 writes R2/R3
                con_word.sel[3] = st0;
                con_word.sel[2] = w.w2;
                con_word.sel[1] = (~st0 & w.w1) | (st0 & w.w2);
                con_word.sel[0] = w.w1;
                st0_set         = ~st0 & w.w2;
            end
            default: begin
                con_word = CTRL_IDLE; // Run and unused codes
            end
        endcase
    end

endmodule

// File: ctrl_sequencer.sv
module ctrl_sequencer (
    input  logic                  t3,
    input  logic                  rst_n,
    input  hdcpu_pkg::mode_e      mode,
    input  hdcpu_pkg::beat_t      w,
    input  hdcpu_pkg::ctrl_word_t con_word,
    input  hdcpu_pkg::ctrl_word_t run_word,
    input  logic                  st0_set,
    output logic                  st0,
    output hdcpu_pkg::ctrl_word_t ctrl
);
    import hdcpu_pkg::*;

    ctrl_word_t next_word;

    // Console phase bit where set wins over clear
    always_ff @(posedge t3) begin
        if (!rst_n) begin
            st0 <= 1'b0;
        end else if (st0_set) begin
            st0 <= 1'b1;
        end else if ((mode == MODE_WR_REG) && st0 && w.w2) begin
            st0 <= 1'b0;
        end
    end

    always_comb begin
        case (mode)
            MODE_RUN:    next_word = run_word;
            MODE_WR_MEM,
            MODE_RD_MEM,
            MODE_RD_REG,
            MODE_WR_REG: next_word = con_word;
            default:     next_word = CTRL_IDLE; // Undefined switch codes
        endcase
    end

    always_ff @(posedge t3) begin
        if (!rst_n) begin
            ctrl <= CTRL_IDLE;
        end else begin
            ctrl <= next_word;
        end
    end

endmodule

// File: cycle_decode.sv
module cycle_decode (
    input  logic                    [2:0] sw,
    input  logic                    [3:0] ir,
    input  logic                          c,
    input  logic                          z,
    output hdcpu_pkg::mode_e              mode,
    output hdcpu_pkg::instr_class_t       cls
);
    import hdcpu_pkg::*;

    opcode_e op;

    // Codes 1011 and 1111 fall to NOP
    always_comb begin
        case (ir)
            4'b0001: op = OP_ADD;
            4'b0010: op = OP_SUB;
            4'b0011: op = OP_AND;
            4'b0100: op = OP_INC;
            4'b0101: op = OP_LD;
            4'b0110: op = OP_ST;
            4'b0111: op = OP_JC;
            4'b1000: op = OP_JZ;
            4'b1001: op = OP_JMP;
            4'b1010: op = OP_OUT;
            4'b1100: op = OP_OR;
            4'b1101: op = OP_XOR;
            4'b1110: op = OP_STP;
            default: op = OP_NOP;
        endcase
    end

    // Codes outside the five modes stay as they are and decode as idle later
    assign mode = mode_e'(sw);

    always_comb begin
        cls.op         = op;
        cls.jump_taken = ((op == OP_JC) && c) || ((op == OP_JZ) && z);
        cls.run        = (mode == MODE_RUN);
    end

endmodule

// File: filelist.f
hdcpu_pkg.sv
cycle_decode.sv
console_ctrl.sv
instr_ctrl.sv
ctrl_sequencer.sv
hdcpu_ctrl.sv
tb_clock.sv
hdcpu_checker.sv
tb_hdcpu.sv

// File: hdcpu_checker.sv
module hdcpu_checker (
    input logic                  t3,
    input logic                  rst_n,
    input logic            [2:0] sw,
    input logic            [3:0] ir,
    input hdcpu_pkg::beat_t      w,
    input logic                  c,
    input logic                  z,
    input logic                  st0,
    input hdcpu_pkg::ctrl_word_t ctrl
);
    import hdcpu_pkg::*;

    ctrl_word_t  exp_q;
    logic        st0_m;
    int unsigned fail_count = 0;

    // Run mode word at beat 2 as columns s m cin ldc ldz drw abus lar long_cyc lpc stop
    function automatic logic [13:0] w2_cols(input logic [3:0] op);
        case (op)
            4'b0001: return 14'b1001_0111110000; // ADD
            4'b0010: return 14'b0110_0011110000; // SUB
            4'b0011: return 14'b1011_1001110000; // AND
            4'b0100: return 14'b0000_0011110000; // INC
            4'b0101: return 14'b1010_1000011100; // LD
            4'b0110: return 14'b1111_1000011100; // ST address
            4'b1001: return 14'b1111_1000010010; // JMP
            4'b1010: return 14'b1010_1000010000; // OUT
            4'b1100: return 14'b1110_1001110000; // OR
            4'b1101: return 14'b0110_1001110000; // XOR
            4'b1110: return 14'b0000_0000000001; // STP
            default: return 14'b0;
        endcase
    endfunction

    function automatic ctrl_word_t rule_word(input logic [2:0] sw_v, input logic [3:0] op,
                                             input beat_t b, input logic cf, input logic zf,
                                             input logic ph);
        ctrl_word_t r;
        r = '0;
        case (sw_v)
            3'b000: begin
                r.lir   = b.w1;
                r.pcinc = b.w1;
                if (b.w2) begin
                    {r.s, r.m, r.cin, r.ldc, r.ldz, r.drw, r.abus,
                     r.lar, r.long_cyc, r.lpc, r.stop} = w2_cols(op);
                    r.pcadd = (op == 4'b0111 && cf) || (op == 4'b1000 && zf);
                end
                if (b.w3 && op == 4'b0101) begin
                    r.drw  = 1'b1;
                    r.mbus = 1'b1;
                end
                if (b.w3 && op == 4'b0110) begin
                    r.s    = 4'b1010; // Data out
                    r.m    = 1'b1;
                    r.abus = 1'b1;
                    r.memw = 1'b1;
                end
            end
            3'b001, 3'b010: begin
                r.stop      = b.w1;
                r.short_cyc = b.w1;
                r.selctl    = b.w1;
                r.sbus      = b.w1 && (sw_v == 3'b001 || !ph);
                r.lar       = b.w1 && !ph;
                r.arinc     = b.w1 && ph;
                r.memw      = b.w1 && ph && sw_v == 3'b001;
                r.mbus      = b.w1 && ph && sw_v == 3'b010;
            end
            3'b011: begin
                r.selctl = b.w1 || b.w2;
                r.stop   = b.w1 || b.w2;
                r.sel    = b.w1 ? 4'b0001 : (b.w2 ? 4'b1011 : 4'b0000);
            end
            3'b100: begin
                r.sbus   = b.w1 || b.w2;
                r.selctl = b.w1 || b.w2;
                r.drw    = b.w1 || b.w2;
                r.stop   = b.w1 || b.w2;
                r.sel    = {ph, b.w2, (b.w1 && !ph) || (b.w2 && ph), b.w1};
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // Phase bit rebuilt from the ports alone
    always_ff @(posedge t3) begin
        if (!rst_n) begin
            st0_m <= 1'b0;
            exp_q <= '0;
        end else begin
            exp_q <= rule_word(sw, ir, w, c, z, st0_m);
            if ((sw == 3'b001 && w.w1) || (sw == 3'b010 && w.w1 && !st0_m) ||
                (sw == 3'b100 && w.w2 && !st0_m)) begin
                st0_m <= 1'b1;
            end else if (sw == 3'b100 && w.w2 && st0_m) begin
                st0_m <= 1'b0;
            end
        end
    end

    a_reset_idle: assert property (@(posedge t3) !rst_n |=> ctrl == '0)
        else begin
            $error("ERR t=%0t ctrl exp=%h got=%h", $time, 29'h0, $sampled(ctrl));
            fail_count++;
        end

    a_word: assert property (@(posedge t3) disable iff (!rst_n) ctrl == exp_q)
        else begin
            $error("ERR t=%0t ctrl exp=%h got=%h", $time, $sampled(exp_q), $sampled(ctrl));
            fail_count++;
        end

    a_phase: assert property (@(posedge t3) disable iff (!rst_n) st0 == st0_m)
        else begin
            $error("ERR t=%0t st0 exp=%b got=%b", $time, $sampled(st0_m), $sampled(st0));
            fail_count++;
        end

endmodule

bind hdcpu_ctrl hdcpu_checker hdcpu_checker_i (.*);

// File: hdcpu_ctrl.sv
module hdcpu_ctrl (
    input  logic                  t3,
    input  logic                  rst_n,
    input  logic            [2:0] sw,
    input  logic            [3:0] ir,
    input  hdcpu_pkg::beat_t      w,
    input  logic                  c,
    input  logic                  z,
    output hdcpu_pkg::ctrl_word_t ctrl
);
    import hdcpu_pkg::*;

    mode_e        mode;
    instr_class_t cls;
    ctrl_word_t   con_word;
    ctrl_word_t   run_word;
    logic         st0_set;
    logic         st0;

    cycle_decode cycle_decode_i (
        .sw   (sw),
        .ir   (ir),
        .c    (c),
        .z    (z),
        .mode (mode),
        .cls  (cls)
    );

    console_ctrl console_ctrl_i (
        .mode     (mode),
        .w        (w),
        .st0      (st0),
        .con_word (con_word),
        .st0_set  (st0_set)
    );

    instr_ctrl instr_ctrl_i (
        .cls      (cls),
        .w        (w),
        .run_word (run_word)
    );

    ctrl_sequencer ctrl_sequencer_i (
        .t3       (t3),
        .rst_n    (rst_n),
        .mode     (mode),
        .w        (w),
        .con_word (con_word),
        .run_word (run_word),
        .st0_set  (st0_set),
        .st0      (st0),
        .ctrl     (ctrl)
    );

endmodule

// File: hdcpu_pkg.sv
package hdcpu_pkg;

    // Console switch settings
    typedef enum logic [2:0] {
        MODE_RUN    = 3'b000,
        MODE_WR_MEM = 3'b001,
        MODE_RD_MEM = 3'b010,
        MODE_RD_REG = 3'b011,
        MODE_WR_REG = 3'b100
    } mode_e;

    // Instruction opcodes, IR[7:4]
    typedef enum logic [3:0] {
        OP_NOP = 4'b0000,
        OP_ADD = 4'b0001,
        OP_SUB = 4'b0010,
        OP_AND = 4'b0011,
        OP_INC = 4'b0100,
        OP_LD  = 4'b0101,
        OP_ST  = 4'b0110,
        OP_JC  = 4'b0111,
        OP_JZ  = 4'b1000,
        OP_JMP = 4'b1001,
        OP_OUT = 4'b1010,
        OP_OR  = 4'b1100,
        OP_XOR = 4'b1101,
        OP_STP = 4'b1110
    } opcode_e;

    // 74181 style function select where M picks logic or arithmetic
    localparam logic [3:0] ALU_ADD    = 4'b1001;
    localparam logic [3:0] ALU_SUB    = 4'b0110;
    localparam logic [3:0] ALU_AND    = 4'b1011;
    localparam logic [3:0] ALU_INC    = 4'b0000;
    localparam logic [3:0] ALU_PASS_B = 4'b1010;
    localparam logic [3:0] ALU_ONES   = 4'b1111;
    localparam logic [3:0] ALU_OR     = 4'b1110;
    localparam logic [3:0] ALU_XOR    = 4'b0110;

    // Register file select for the read-register console pass
    localparam logic [3:0] SEL_RD_FIRST  = 4'b0001; // R0 / R1
    localparam logic [3:0] SEL_RD_SECOND = 4'b1011; // R2 / R3

    typedef struct packed {
        logic       ldc;
        logic       ldz;
        logic       cin;
        logic [3:0] s;
        logic [3:0] sel;
        logic       m;
        logic       abus;
        logic       drw;
        logic       pcinc;
        logic       lpc;
        logic       lar;
        logic       pcadd;
        logic       arinc;
        logic       selctl;
        logic       memw;
        logic       stop;
        logic       lir;
        logic       sbus;
        logic       mbus;
        logic       short_cyc;
        logic       long_cyc;
    } ctrl_word_t;

    // Beat levels from the timing generator
    typedef struct packed {
        logic w1;
        logic w2;
        logic w3;
    } beat_t;

    typedef struct packed {
        opcode_e op;
        logic    jump_taken; // JC with C, JZ with Z
        logic    run;
    } instr_class_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

// File: instr_ctrl.sv
module instr_ctrl (
    input  hdcpu_pkg::instr_class_t cls,
    input  hdcpu_pkg::beat_t        w,
    output hdcpu_pkg::ctrl_word_t   run_word
);
    import hdcpu_pkg::*;

    logic alu_op;

    // ALU function for the register to register group
    function automatic logic [3:0] alu_sel(input opcode_e op);
        logic [3:0] code;
        case (op)
            OP_ADD:  code = ALU_ADD;
            OP_SUB:  code = ALU_SUB;
            OP_AND:  code = ALU_AND;
            OP_INC:  code = ALU_INC;
            OP_OR:   code = ALU_OR;
            OP_XOR:  code = ALU_XOR;
            default: code = 4'b0000;
        endcase
        return code;
    endfunction

    assign alu_op = (cls.op == OP_ADD) || (cls.op == OP_SUB) || (cls.op == OP_AND) ||
                    (cls.op == OP_INC) || (cls.op == OP_OR)  || (cls.op == OP_XOR);

    always_comb begin
        run_word = CTRL_IDLE;
        if (cls.run) begin
            // Fetch
            run_word.lir   = w.w1;
            run_word.pcinc = w.w1;

            if (alu_op) begin
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
                run_word.ldc  = w.w2 & ((cls.op == OP_ADD) || (cls.op == OP_SUB) ||
                                        (cls.op == OP_INC));
                run_word.cin  = w.w2 & (cls.op == OP_ADD);
                run_word.m    = w.w2 & ((cls.op == OP_AND) || (cls.op == OP_OR) ||
                                        (cls.op == OP_XOR));
                if (w.w2) begin
                    run_word.s = alu_sel(cls.op);
                end
            end

            case (cls.op)
                OP_LD: begin
                    run_word.m        = w.w2;
                    run_word.abus     = w.w2;
                    run_word.lar      = w.w2;
                    run_word.long_cyc = w.w2;
                    run_word.drw      = w.w3;
                    run_word.mbus     = w.w3;
                    if (w.w2) begin
                        run_word.s = ALU_PASS_B;
                    end
                end
                OP_ST: begin
                    // Address out at w2, data out at w3
                    run_word.m        = w.w2 | w.w3;
                    run_word.abus     = w.w2 | w.w3;
                    run_word.lar      = w.w2;
                    run_word.long_cyc = w.w2;
                    run_word.memw     = w.w3;
                    if (w.w2) begin
                        run_word.s = ALU_ONES;
                    end else if (w.w3) begin
                        run_word.s = ALU_PASS_B;
                    end
                end
                OP_JC, OP_JZ: begin
                    run_word.pcadd = w.w2 & cls.jump_taken;
                end
                OP_JMP: begin
                    run_word.m    = w.w2;
                    run_word.abus = w.w2;
                    run_word.lpc  = w.w2;
                    if (w.w2) begin
                        run_word.s = ALU_ONES;
                    end
                end
                OP_OUT: begin
                    run_word.m    = w.w2;
                    run_word.abus = w.w2;
                    if (w.w2) begin
                        run_word.s = ALU_PASS_B;
                    end
                end
                OP_STP: begin
                    run_word.stop = w.w2;
                end
                default: begin
                    run_word.pcadd = 1'b0; // ALU group and NOP handled above
                end
            endcase
        end
    end

endmodule

// File: tb_clock.sv
module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD = 4; // Period of 8

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: tb_hdcpu.sv
module tb_hdcpu;
    import hdcpu_pkg::*;

    localparam int MAX_CYCLES = 400; // Tests take about 200 cycles

    logic        t3;
    logic        rst_n;
    logic  [2:0] sw;
    logic  [3:0] ir;
    beat_t       w;
    logic        c;
    logic        z;
    ctrl_word_t  ctrl;

    int          seed = 32'h35d14a40;
    int          cycles = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned seen_fails = 0;

    // ALU group, OUT, then two codes that decode as NOP
    logic  [3:0] alu_codes [9] = '{4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b1100,
                                   4'b1101, 4'b1010, 4'b1011, 4'b1111};

    tb_clock clock_i (.clk(t3));

    hdcpu_ctrl hdcpu_ctrl_i (
        .t3    (t3),
        .rst_n (rst_n),
        .sw    (sw),
        .ir    (ir),
        .w     (w),
        .c     (c),
        .z     (z),
        .ctrl  (ctrl)
    );

    always @(posedge t3) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic next_beat(input beat_t b);
        @(posedge t3);
        #2;
        w = b;
    endtask

    // One pass of w1, w2, w3 with the switches and opcode held
    task automatic issue(input logic [2:0] mode, input logic [3:0] op,
                         input logic cf, input logic zf);
        @(posedge t3);
        #2;
        sw = mode;
        ir = op;
        c  = cf;
        z  = zf;
        w  = 3'b100;
        next_beat(3'b010);
        next_beat(3'b001);
    endtask

    task automatic pulse_reset(input int n);
        @(posedge t3);
        #2;
        rst_n = 1'b0;
        w     = 3'b000;
        repeat (n) @(posedge t3);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic end_test(input string name);
        int unsigned now_fails;
        repeat (2) next_beat(3'b000); // Last word reaches the checker
        now_fails = hdcpu_ctrl_i.hdcpu_checker_i.fail_count;
        tests_run++;
        if (now_fails != seen_fails) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d assertion failures", tests_run, name, now_fails - seen_fails);
        seen_fails = now_fails;
    endtask

    initial begin
        int idx;
        int rnd;
        rst_n = 1'b0;
        sw    = 3'b000;
        ir    = 4'b0000;
        w     = 3'b000;
        c     = 1'b0;
        z     = 1'b0;
        repeat (8) @(posedge t3);
        #2;
        rst_n = 1'b1;

        for (idx = 0; idx < 16; idx++) begin
            issue(3'b000, 4'(idx), 1'b0, 1'b0);
        end
        end_test("fetch");

        for (idx = 0; idx < 9; idx++) begin
            issue(3'b000, alu_codes[idx], 1'b0, 1'b0);
        end
        repeat (8) begin
            rnd = $random(seed);
            issue(3'b000, alu_codes[$unsigned(rnd) % 9], rnd[4], rnd[5]);
        end
        end_test("alu_out");

        issue(3'b000, 4'b0101, 1'b0, 1'b0);
        issue(3'b000, 4'b0110, 1'b0, 1'b0);
        issue(3'b000, 4'b1110, 1'b0, 1'b0);
        end_test("ld_st_stp");

        for (idx = 0; idx < 4; idx++) begin
            issue(3'b000, 4'b0111, idx[0], idx[1]); // JC
            issue(3'b000, 4'b1000, idx[0], idx[1]); // JZ
        end
        issue(3'b000, 4'b1001, 1'b0, 1'b0);
        end_test("jumps");

        pulse_reset(2);
        repeat (4) issue(3'b001, 4'b0000, 1'b0, 1'b0);
        pulse_reset(2);
        repeat (4) issue(3'b010, 4'b0000, 1'b0, 1'b0);
        end_test("console_mem");

        pulse_reset(2);
        repeat (2) issue(3'b100, 4'b0000, 1'b0, 1'b0);
        repeat (2) issue(3'b011, 4'b0000, 1'b0, 1'b0);
        end_test("console_reg");

        $display("tests run %0d, tests failed %0d, assertion failures %0d",
                 tests_run, tests_failed, seen_fails);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
